// ==== design/if_pkg.sv ====
package if_pkg;

    // Datapath width for PC, addresses and instruction words
    localparam int NBITS = 32;

    // Instruction memory geometry in 32-bit words
    localparam int IMEM_DEPTH = 256;
    localparam int IMEM_AW    = $clog2(IMEM_DEPTH);    // Word index width

    // Sequential PC increment in bytes
    localparam logic [NBITS-1:0] PC_STEP = 32'd4;

    // First fetch address after reset
    localparam logic [NBITS-1:0] RESET_PC = 32'h0000_0000;

    // Bubble marker in the IF/ID register
    localparam logic [NBITS-1:0] NOP_INSTR = 32'h0000_0000;

endpackage

// ==== design/program_counter.sv ====
`timescale 1ns / 1ps

module program_counter (
    input   logic                       i_clk,
    input   logic                       i_rst_n,              // Sync reset, active low

    // Next PC selection
    input   logic                       i_sel_jump,           // Take the jump target
    input   logic                       i_hazard_detected,    // Hold the current PC
    input   logic [if_pkg::NBITS-1:0]   i_jump_pc,            // Jump target from a later stage

    // Outputs
    output  logic [if_pkg::NBITS-1:0]   o_pc,                 // Current fetch address
    output  logic [if_pkg::NBITS-1:0]   o_pc_plus4            // Sequential address
);

    import if_pkg::*;

    logic [NBITS-1:0] pc_q;                                   // PC register
    logic [NBITS-1:0] pc_seq;                                 // PC plus one word
    logic [NBITS-1:0] pc_nxt;                                 // Value loaded on the next edge

    // Sequential increment, wraps at the top of the address space
    assign pc_seq = pc_q + PC_STEP;

    // Next PC by priority
    // A stall wins over a jump, so a jump raised under a hazard is dropped here
    // and must be held by the requesting stage until the hazard clears
    always_comb begin
        if (i_hazard_detected) begin
            pc_nxt = pc_q;                                    // Stall
        end else if (i_sel_jump) begin
            pc_nxt = i_jump_pc;                               // Redirect
        end else begin
            pc_nxt = pc_seq;                                  // Fall through
        end
    end

    always_ff @(posedge i_clk) begin
        if (!i_rst_n) begin
            pc_q <= RESET_PC;
        end else begin
            pc_q <= pc_nxt;
        end
    end

    assign o_pc       = pc_q;
    assign o_pc_plus4 = pc_seq;                               // Also the link value for decode

endmodule

// ==== design/instruction_memory.sv ====
`timescale 1ns / 1ps

module instruction_memory (
    input   logic                       i_clk,

    // Program load port
    input   logic                       i_wr_en,              // Write strobe
    input   logic [if_pkg::NBITS-1:0]   i_addr_wr,            // Byte address of the load
    input   logic [if_pkg::NBITS-1:0]   i_data,               // Word to store

    // Fetch port
    input   logic [if_pkg::NBITS-1:0]   i_addr,               // Byte address from the PC
    output  logic [if_pkg::NBITS-1:0]   o_data                // Fetched instruction
);

    import if_pkg::*;

    logic [NBITS-1:0]   mem [IMEM_DEPTH];                     // Instruction storage

    logic [IMEM_AW-1:0] wr_idx;
    logic [IMEM_AW-1:0] rd_idx;

    // Word index from a byte address
    // Bits above the index wrap, the two byte offset bits are ignored
    assign wr_idx = i_addr_wr[IMEM_AW+1:2];
    assign rd_idx = i_addr[IMEM_AW+1:2];

    // Synchronous load
    always_ff @(posedge i_clk) begin
        if (i_wr_en) begin
            mem[wr_idx] <= i_data;
        end
    end

    // Asynchronous read, a word stored at the current PC shows up
    // on o_data right after the write edge
    assign o_data = mem[rd_idx];

endmodule

// ==== design/if_id_register.sv ====
`timescale 1ns / 1ps

module if_id_register (
    input   logic                       i_clk,
    input   logic                       i_rst_n,              // Sync reset, active low

    // Control
    input   logic                       i_stall,              // Hold contents
    input   logic                       i_flush,              // Squash the wrong path fetch

    // From fetch
    input   logic [if_pkg::NBITS-1:0]   i_pc_plus4,           // Sequential PC of this fetch
    input   logic [if_pkg::NBITS-1:0]   i_instr,              // Fetched word

    // To decode
    output  logic                       o_valid,              // Entry carries a real instruction
    output  logic [if_pkg::NBITS-1:0]   o_pc_plus4,
    output  logic [if_pkg::NBITS-1:0]   o_instr
);

    import if_pkg::*;

    logic             valid_q;
    logic [NBITS-1:0] pc_plus4_q;
    logic [NBITS-1:0] instr_q;

    // Reset and flush leave the same bubble behind
    // Stall is checked before flush so a held entry survives a pending jump
    always_ff @(posedge i_clk) begin
        if (!i_rst_n) begin
            valid_q    <= 1'b0;
            pc_plus4_q <= '0;
            instr_q    <= NOP_INSTR;
        end else if (i_stall) begin
            valid_q    <= valid_q;                            // Hold
            pc_plus4_q <= pc_plus4_q;
            instr_q    <= instr_q;
        end else if (i_flush) begin
            valid_q    <= 1'b0;                               // Bubble
            pc_plus4_q <= '0;
            instr_q    <= NOP_INSTR;
        end else begin
            valid_q    <= 1'b1;                               // Capture new fetch
            pc_plus4_q <= i_pc_plus4;
            instr_q    <= i_instr;
        end
    end

    assign o_valid    = valid_q;
    assign o_pc_plus4 = pc_plus4_q;
    assign o_instr    = instr_q;

endmodule

// ==== design/instruction_fetch.sv ====
`timescale 1ns / 1ps

module instruction_fetch (
    input   logic                       i_clk,
    input   logic                       i_rst_n,              // Sync reset, active low

    // Jump request from a later stage
    input   logic                       i_pc_mux_ctrl,        // Jump select
    input   logic [if_pkg::NBITS-1:0]   i_eff_addr,           // Jump target

    // Hazard unit
    input   logic                       i_hazard_detected,    // Stall fetch

    // Instruction memory load
    input   logic                       i_inst_mem_wr_en,
    input   logic [if_pkg::NBITS-1:0]   i_inst_mem_addr,      // Byte address
    input   logic [if_pkg::NBITS-1:0]   i_inst_mem_data,

    // Current fetch
    output  logic [if_pkg::NBITS-1:0]   o_pc,
    output  logic [if_pkg::NBITS-1:0]   o_instr,              // Word at o_pc, same cycle

    // IF/ID register
    output  logic                       o_id_valid,
    output  logic [if_pkg::NBITS-1:0]   o_id_pc_plus4,
    output  logic [if_pkg::NBITS-1:0]   o_id_instr
);

    import if_pkg::*;

    logic [NBITS-1:0] pc;                                     // Fetch address
    logic [NBITS-1:0] pc_plus4;                               // Sequential address
    logic [NBITS-1:0] fetch_instr;                            // Word read at pc

    program_counter u_pc (
        .i_clk             (i_clk),
        .i_rst_n           (i_rst_n),
        .i_sel_jump        (i_pc_mux_ctrl),
        .i_hazard_detected (i_hazard_detected),
        .i_jump_pc         (i_eff_addr),
        .o_pc              (pc),
        .o_pc_plus4        (pc_plus4)
    );

    instruction_memory u_imem (
        .i_clk     (i_clk),
        .i_wr_en   (i_inst_mem_wr_en),
        .i_addr_wr (i_inst_mem_addr),
        .i_data    (i_inst_mem_data),
        .i_addr    (pc),                                      // Fetch port follows the PC
        .o_data    (fetch_instr)
    );

    // The jump select doubles as the flush for the wrong path fetch
    if_id_register u_if_id (
        .i_clk      (i_clk),
        .i_rst_n    (i_rst_n),
        .i_stall    (i_hazard_detected),
        .i_flush    (i_pc_mux_ctrl),
        .i_pc_plus4 (pc_plus4),
        .i_instr    (fetch_instr),
        .o_valid    (o_id_valid),
        .o_pc_plus4 (o_id_pc_plus4),
        .o_instr    (o_id_instr)
    );

    assign o_pc    = pc;
    assign o_instr = fetch_instr;

endmodule

// ==== test/tb_clock_gen.sv ====
`timescale 1ns/1ps

module tb_clock_gen (
    output logic o_clk
);

    localparam realtime HALF_PERIOD = 2.0;    // 4 ns period

    initial begin
        o_clk = 1'b0;
    end

    always begin
        #(HALF_PERIOD);
        o_clk = ~o_clk;
    end

endmodule

// ==== test/instruction_fetch_chk.sv ====
`timescale 1ns/1ps

module instruction_fetch_chk (
    input logic                     i_clk,
    input logic                     i_rst_n,
    input logic                     i_pc_mux_ctrl,        // Jump select
    input logic                     i_hazard_detected,    // Stall
    input logic [if_pkg::NBITS-1:0] i_pc,
    input logic                     i_id_valid,
    input logic [if_pkg::NBITS-1:0] i_id_pc_plus4,
    input logic [if_pkg::NBITS-1:0] i_id_instr
);

    int assert_fails = 0;                                 // Failed assertions so far

    // A stall freezes the PC and the whole IF/ID entry
    property p_stall_hold;
        @(posedge i_clk) (i_rst_n && i_hazard_detected) |=>
            ($stable(i_pc) && $stable(i_id_valid) &&
             $stable(i_id_pc_plus4) && $stable(i_id_instr));
    endproperty

    // Jump without stall squashes the wrong path fetch
    property p_jump_bubble;
        @(posedge i_clk) (i_rst_n && i_pc_mux_ctrl && !i_hazard_detected) |=> !i_id_valid;
    endproperty

    property p_pc_aligned;
        @(posedge i_clk) i_rst_n |-> (i_pc[1:0] == 2'b00);
    endproperty

    a_stall_hold: assert property (p_stall_hold)
        else begin
            $error("PC or IF/ID register changed while stalled");
            assert_fails = assert_fails + 1;
        end

    a_jump_bubble: assert property (p_jump_bubble)
        else begin
            $error("IF/ID register still valid after a jump");
            assert_fails = assert_fails + 1;
        end

    a_pc_aligned: assert property (p_pc_aligned)
        else begin
            $error("PC is not word aligned");
            assert_fails = assert_fails + 1;
        end

endmodule

// ==== test/tb_instruction_fetch.sv ====
`timescale 1ns/1ps

module tb_instruction_fetch;

    import if_pkg::*;

    localparam logic [31:0] SEED  = 32'h64be44b5;
    localparam int RESET_CYCLES   = 2;
    localparam int SEQ_CYCLES     = 50;               // Plain sequential fetch after the load
    localparam int RUN_CYCLES     = 1200;             // Random stall, jump and write traffic
    localparam int TIMEOUT_CYCLES = 2000;             // About 1510 cycles planned, plus margin

    logic             clk;
    logic             rst_n;
    logic             pc_mux_ctrl;
    logic [NBITS-1:0] eff_addr;
    logic             hazard_detected;
    logic             inst_mem_wr_en;
    logic [NBITS-1:0] inst_mem_addr;
    logic [NBITS-1:0] inst_mem_data;
    logic [NBITS-1:0] pc;
    logic [NBITS-1:0] instr;
    logic             id_valid;
    logic [NBITS-1:0] id_pc_plus4;
    logic [NBITS-1:0] id_instr;

    // Reference model of the fetch stage
    logic [NBITS-1:0] model_mem [IMEM_DEPTH];
    bit               model_known [IMEM_DEPTH];       // Word has been written
    logic [NBITS-1:0] model_pc;
    logic             model_valid;
    logic [NBITS-1:0] model_pc_plus4;
    logic [NBITS-1:0] model_instr;

    int cycle_count = 0;

    tb_clock_gen u_clk_gen (
        .o_clk (clk)
    );

    instruction_fetch instruction_fetch_inst (
        .i_clk             (clk),
        .i_rst_n           (rst_n),
        .i_pc_mux_ctrl     (pc_mux_ctrl),
        .i_eff_addr        (eff_addr),
        .i_hazard_detected (hazard_detected),
        .i_inst_mem_wr_en  (inst_mem_wr_en),
        .i_inst_mem_addr   (inst_mem_addr),
        .i_inst_mem_data   (inst_mem_data),
        .o_pc              (pc),
        .o_instr           (instr),
        .o_id_valid        (id_valid),
        .o_id_pc_plus4     (id_pc_plus4),
        .o_id_instr        (id_instr)
    );

    bind instruction_fetch instruction_fetch_chk u_chk (
        .i_clk             (i_clk),
        .i_rst_n           (i_rst_n),
        .i_pc_mux_ctrl     (i_pc_mux_ctrl),
        .i_hazard_detected (i_hazard_detected),
        .i_pc              (o_pc),
        .i_id_valid        (o_id_valid),
        .i_id_pc_plus4     (o_id_pc_plus4),
        .i_id_instr        (o_id_instr)
    );

    always @(posedge clk) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count >= TIMEOUT_CYCLES) begin
            $display("Timeout: the run did not finish within %0d cycles", TIMEOUT_CYCLES);
            $display("TESTBENCH FAILED");
            $fatal(1);
        end
    end

    // Word index of a byte address, upper bits wrap
    function automatic logic [IMEM_AW-1:0] word_index(input logic [NBITS-1:0] addr);
        return addr[IMEM_AW+1:2];
    endfunction

    function automatic logic [NBITS-1:0] random_target();
        logic [NBITS-1:0] addr;
        if ($urandom_range(1, 0) == 0) begin
            addr = $urandom_range(IMEM_DEPTH - 1, 0) * 4;     // Inside the memory
        end else begin
            addr = $urandom();                                // Anywhere, wraps onto the memory
        end
        return {addr[NBITS-1:2], 2'b00};
    endfunction

    task automatic check_value(input string name, input logic [NBITS-1:0] expected,
                               input logic [NBITS-1:0] actual);
        if (actual !== expected) begin
            $display("FAILED %s expected %h actual %h", name, expected, actual);
            $display("TESTBENCH FAILED");
            $fatal(1, "Stopped at the first mismatch");
        end
    endtask

    // Stop as soon as the bound checker has seen a failing assertion
    task automatic check_assertions();
        if (instruction_fetch_inst.u_chk.assert_fails != 0) begin
            $display("%0d assertion failures in the bound checker",
                     instruction_fetch_inst.u_chk.assert_fails);
            $display("TESTBENCH FAILED");
            $fatal(1);
        end
    endtask

    // Model step for one rising edge, using the inputs sampled at that edge
    task automatic advance_model();
        if (!rst_n) begin
            model_pc       = RESET_PC;
            model_valid    = 1'b0;
            model_pc_plus4 = '0;
            model_instr    = NOP_INSTR;
        end else if (hazard_detected) begin
            model_pc = model_pc;                              // Everything holds
        end else if (pc_mux_ctrl) begin
            model_valid    = 1'b0;                            // Bubble
            model_pc_plus4 = '0;
            model_instr    = NOP_INSTR;
            model_pc       = eff_addr;
        end else begin
            model_valid    = 1'b1;
            model_pc_plus4 = model_pc + PC_STEP;
            model_instr    = model_mem[word_index(model_pc)]; // Word before this edge's write
            model_pc       = model_pc + PC_STEP;
        end
        if (inst_mem_wr_en) begin
            model_mem[word_index(inst_mem_addr)]   = inst_mem_data;
            model_known[word_index(inst_mem_addr)] = 1'b1;
        end
    endtask

    task automatic check_outputs();
        check_value("o_pc", model_pc, pc);
        if (model_known[word_index(model_pc)]) begin
            check_value("o_instr", model_mem[word_index(model_pc)], instr);
        end
        check_value("o_id_valid", model_valid, id_valid);
        check_value("o_id_pc_plus4", model_pc_plus4, id_pc_plus4);
        check_value("o_id_instr", model_instr, id_instr);
    endtask

    // One cycle: step the model, queue inputs for the next edge, check mid cycle
    task automatic tick(input logic rst, input logic hz, input logic jmp,
                        input logic [NBITS-1:0] tgt, input logic we,
                        input logic [NBITS-1:0] wa, input logic [NBITS-1:0] wd);
        @(posedge clk);
        advance_model();
        rst_n           <= rst;
        hazard_detected <= hz;
        pc_mux_ctrl     <= jmp;
        eff_addr        <= tgt;
        inst_mem_wr_en  <= we;
        inst_mem_addr   <= wa;
        inst_mem_data   <= wd;
        @(negedge clk);
        check_outputs();
        check_assertions();
    endtask

    initial begin : stimulus
        int               stall_left;
        logic             hz;
        logic             jmp;
        logic             we;
        logic [NBITS-1:0] tgt;
        logic [NBITS-1:0] wa;
        logic [NBITS-1:0] wd;

        void'($urandom(SEED));
        rst_n           = 1'b0;
        pc_mux_ctrl     = 1'b0;
        eff_addr        = '0;
        hazard_detected = 1'b1;
        inst_mem_wr_en  = 1'b0;
        inst_mem_addr   = '0;
        inst_mem_data   = '0;
        stall_left      = 0;

        for (int c = 1; c < RESET_CYCLES; c++) begin
            tick(1'b0, 1'b1, 1'b0, '0, 1'b0, '0, '0);
        end
        check_value("o_pc after reset", RESET_PC, pc);
        check_value("o_id_valid after reset", 1'b0, id_valid);
        check_value("o_id_instr after reset", NOP_INSTR, id_instr);

        // Load the whole memory under stall
        for (int i = 0; i < IMEM_DEPTH; i++) begin
            tick(1'b1, 1'b1, 1'b0, '0, 1'b1, i * 4, $urandom());
        end

        for (int c = 0; c < SEQ_CYCLES; c++) begin
            tick(1'b1, 1'b0, 1'b0, '0, 1'b0, '0, '0);
        end

        for (int c = 0; c < RUN_CYCLES; c++) begin
            hz  = 1'b0;
            jmp = 1'b0;
            tgt = '0;
            we  = 1'b0;
            wa  = '0;
            wd  = '0;
            if (stall_left > 0) begin
                hz         = 1'b1;
                stall_left = stall_left - 1;
                if ($urandom_range(99, 0) < 30) begin
                    jmp = 1'b1;                               // Dropped under the stall
                    tgt = random_target();
                end
            end else if ($urandom_range(99, 0) < 8) begin
                hz         = 1'b1;
                stall_left = $urandom_range(5, 0);
            end else if ($urandom_range(99, 0) < 10) begin
                jmp = 1'b1;
                tgt = random_target();
            end
            if ($urandom_range(99, 0) < 12) begin
                we = 1'b1;
                wd = $urandom();
                wa = ($urandom_range(1, 0) == 0) ? model_pc : $urandom();
            end
            tick(1'b1, hz, jmp, tgt, we, wa, wd);
        end
        tick(1'b1, 1'b0, 1'b0, '0, 1'b0, '0, '0);        // Let the last inputs take effect
        @(posedge clk);

        if (instruction_fetch_inst.u_chk.assert_fails != 0) begin
            $display("%0d assertion failures in the bound checker",
                     instruction_fetch_inst.u_chk.assert_fails);
            $display("TESTBENCH FAILED");
            $fatal(1);
        end else begin
            $display("TESTBENCH PASSED");
            $finish;
        end
    end

endmodule

// ==== sim.f ====
design/if_pkg.sv
design/program_counter.sv
design/instruction_memory.sv
design/if_id_register.sv
design/instruction_fetch.sv
test/tb_clock_gen.sv
test/instruction_fetch_chk.sv
test/tb_instruction_fetch.sv

// ==== Bender.yml ====
package:
  name: instruction_fetch

sources:
  # Fetch stage RTL, package first
  - files:
      - design/if_pkg.sv
      - design/program_counter.sv
      - design/instruction_memory.sv
      - design/if_id_register.sv
      - design/instruction_fetch.sv

  # Testbench with clock source and bound checker
  - target: test
    files:
      - test/tb_clock_gen.sv
      - test/instruction_fetch_chk.sv
      - test/tb_instruction_fetch.sv
